//--- rider_pkg.sv
package rider_pkg;

  // Firmware revision, reported in register 0
  localparam logic [7:0] MAJOR_REV = 8'd3;
  localparam logic [7:0] MINOR_REV = 8'd1;
  localparam logic [7:0] PATCH_REV = 8'd0;

  // Soft error words, used for both thresholds and counts
  typedef struct packed {
    logic [31:0] data_corrupt;   // Checksum mismatch
    logic [31:0] unknown_ttc;    // Unknown TTC broadcast command
    logic [31:0] ddr3_overflow;  // DDR3 overflow
  } soft_cnt_t;

  // Hard errors, LSB first in register 1
  typedef struct packed {
    logic trig_type_cm;  // Bit 7
    logic trig_num_cm;
    logic trig_type_tt;
    logic trig_num_tt;
    logic pll_unlock;
    logic trig_rate;     // Bit 2
    logic unknown_ttc;
    logic data_corrupt;  // Bit 0
  } hard_err_t;

  // Latest trigger number and its timestamp
  typedef struct packed {
    logic [23:0] trig_num;
    logic [43:0] trig_timestamp;
  } trig_info_t;

  // TTS encoding as seen by the DAQ
  typedef enum logic [3:0] {
    TTS_WARN  = 4'd1,
    TTS_BUSY  = 4'd4,
    TTS_READY = 4'd8,
    TTS_ERROR = 4'd12
  } tts_state_e;

  localparam int unsigned NUM_STATUS_REGS = 12;

  typedef logic [3:0] status_addr_t;

  // Status register map
  localparam status_addr_t REG_VERSION   = 4'd0;
  localparam status_addr_t REG_ERROR     = 4'd1;
  localparam status_addr_t REG_TTS       = 4'd2;
  localparam status_addr_t REG_TRIG_NUM  = 4'd3;
  localparam status_addr_t REG_TS_LSB    = 4'd4;
  localparam status_addr_t REG_TS_MSB    = 4'd5;
  localparam status_addr_t REG_THRES_DC  = 4'd6;
  localparam status_addr_t REG_CNT_DC    = 4'd7;
  localparam status_addr_t REG_THRES_TTC = 4'd8;
  localparam status_addr_t REG_CNT_TTC   = 4'd9;
  localparam status_addr_t REG_THRES_DDR = 4'd10;
  localparam status_addr_t REG_CNT_DDR   = 4'd11;

endpackage

//--- soft_err_counter.sv
`timescale 1ns/1ps

module soft_err_counter (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cs_mismatch,    // Checksum mismatch strobe
  input  logic                unknown_cmd,    // Unknown TTC command strobe
  input  logic                ddr3_overflow,  // DDR3 overflow strobe
  input  logic                err_clear,
  input  rider_pkg::soft_cnt_t thresholds,
  output rider_pkg::soft_cnt_t counts,
  output logic                err_data_corrupt,
  output logic                err_unknown_ttc
);

  import rider_pkg::*;

  // Index 2 is data corruption, 0 is DDR3, same order as soft_cnt_t
  logic [2:0]       strobe;
  logic [2:0][31:0] cnt_q;

  assign strobe = {cs_mismatch, unknown_cmd, ddr3_overflow};

  // Saturating counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (err_clear) begin
      cnt_q <= '0;  // Host clears all counts at once
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (strobe[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 32'd1;  // Hold at all ones
        end
      end
    end
  end

  assign counts = cnt_q;

  // Hard error once the count passes the threshold
  assign err_data_corrupt = counts.data_corrupt > thresholds.data_corrupt;
  assign err_unknown_ttc  = counts.unknown_ttc  > thresholds.unknown_ttc;
  // DDR3 count only reported, the warning comes from outside

  // Counts only move down through a host clear
  a_cnt_monotonic: assert property (
    @(posedge clk) disable iff (!arst_n)
    !err_clear |=> (counts.data_corrupt  >= $past(counts.data_corrupt)) &&
                   (counts.unknown_ttc   >= $past(counts.unknown_ttc)) &&
                   (counts.ddr3_overflow >= $past(counts.ddr3_overflow))
  ) else $error("soft error count decreased without err_clear");

endmodule

//--- trig_monitor.sv
`timescale 1ns/1ps

module trig_monitor #(
  parameter int unsigned WINDOW_CYCLES = 64,  // Rate window length
  parameter int unsigned MAX_TRIGS     = 4    // Allowed triggers per window
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  trig,
  input  logic                  err_clear,
  output rider_pkg::trig_info_t trig_info,
  output logic                  trig_rate_err
);

  import rider_pkg::*;

  localparam int unsigned WIN_W   = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;
  localparam int unsigned TALLY_W = $clog2(WINDOW_CYCLES + 1);  // Holds a full window

  logic [43:0]        ts_q;         // Free-running timestamp
  logic [WIN_W-1:0]   win_cnt_q;
  logic               win_last;
  logic [TALLY_W-1:0] tally_q;      // Triggers so far in this window
  logic [TALLY_W-1:0] tally_total;  // Including this cycle's trigger

  assign win_last    = win_cnt_q == WIN_W'(WINDOW_CYCLES - 1);
  assign tally_total = tally_q + TALLY_W'(trig);

  // Timestamp and window counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ts_q      <= '0;
      win_cnt_q <= '0;
    end else begin
      ts_q      <= ts_q + 44'd1;
      win_cnt_q <= win_last ? '0 : win_cnt_q + WIN_W'(1);
    end
  end

  // Trigger number and captured timestamp
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trig_info <= '0;
    end else if (trig) begin
      trig_info.trig_num       <= trig_info.trig_num + 24'd1;
      trig_info.trig_timestamp <= ts_q;  // Time of this trigger
    end
  end

  // Per-window tally and sticky rate error
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tally_q       <= '0;
      trig_rate_err <= 1'b0;
    end else begin
      tally_q <= win_last ? '0 : tally_total;  // Restart each window
      if (err_clear) begin
        trig_rate_err <= 1'b0;
      end else if (win_last && (32'(tally_total) > MAX_TRIGS)) begin
        trig_rate_err <= 1'b1;  // Too many in this window
      end
    end
  end

  // Every window starts with an empty tally
  a_tally_window: assert property (
    @(posedge clk) disable iff (!arst_n)
    (win_cnt_q == '0) |-> (tally_q == '0)
  ) else $error("trigger tally not reset at window start");

endmodule

//--- tts_fsm.sv
`timescale 1ns/1ps

module tts_fsm (
  input  logic                  clk,
  input  logic                  arst_n,
  input  rider_pkg::hard_err_t  hard_err,
  input  logic                  ddr3_overflow_warning,
  input  logic                  daq_almost_full,
  input  logic                  err_clear,
  output rider_pkg::tts_state_e tts_state,
  output rider_pkg::hard_err_t  err_latched  // Sticky copy of hard_err
);

  import rider_pkg::*;

  tts_state_e state_d;
  logic       err_set;
  logic       err_hold;

  // Causes seen during a clear are stale, they drop at the same edge
  assign err_set  = (|hard_err) && !err_clear;
  assign err_hold = (tts_state == TTS_ERROR) && !err_clear;  // ERROR is sticky

  // Priority ERROR > BUSY > WARN > READY
  always_comb begin
    state_d = TTS_READY;
    case (tts_state)
      TTS_ERROR: begin
        if (err_hold) begin
          state_d = TTS_ERROR;
        end else if (daq_almost_full) begin
          state_d = TTS_BUSY;
        end else if (ddr3_overflow_warning) begin
          state_d = TTS_WARN;
        end
      end
      default: begin  // READY, WARN and BUSY follow the inputs
        if (err_set) begin
          state_d = TTS_ERROR;
        end else if (daq_almost_full) begin
          state_d = TTS_BUSY;
        end else if (ddr3_overflow_warning) begin
          state_d = TTS_WARN;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tts_state   <= TTS_READY;
      err_latched <= '0;
    end else begin
      tts_state <= state_d;
      if (err_clear) begin
        err_latched <= '0;
      end else begin
        err_latched <= err_latched | hard_err;  // Accumulate each bit
      end
    end
  end

  // Only a host clear gets out of ERROR
  a_error_sticky: assert property (
    @(posedge clk) disable iff (!arst_n)
    (tts_state == TTS_ERROR) && !err_clear |=> (tts_state == TTS_ERROR)
  ) else $error("TTS left ERROR without err_clear");

endmodule

//--- status_reg_block.sv
`timescale 1ns/1ps

module status_reg_block (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    rd_en,
  input  rider_pkg::status_addr_t rd_addr,
  input  logic                    prog_chan_done,
  input  logic                    async_mode,
  input  logic                    ddr3_overflow_warning,
  input  logic                    daq_almost_full,
  input  rider_pkg::hard_err_t    err_latched,
  input  rider_pkg::tts_state_e   tts_state,
  input  rider_pkg::trig_info_t   trig_info,
  input  rider_pkg::soft_cnt_t    thresholds,
  input  rider_pkg::soft_cnt_t    counts,
  output logic [31:0]             rd_data,
  output logic                    rd_valid
);

  import rider_pkg::*;

  logic [31:0] words [NUM_STATUS_REGS];
  logic [31:0] rd_word;  // Addressed word before the output register

  // Register map packing
  always_comb begin
    // FPGA status and firmware revision
    words[REG_VERSION] = {1'b0, prog_chan_done, async_mode, 5'd0,
                          MAJOR_REV, MINOR_REV, PATCH_REV};
    // Latched errors, warning above them
    words[REG_ERROR]   = {23'd0, ddr3_overflow_warning, err_latched};
    words[REG_TTS]     = {27'd0, daq_almost_full, tts_state};
    words[REG_TRIG_NUM] = {8'd0, trig_info.trig_num};
    // Trigger timestamp split over two words
    words[REG_TS_LSB]  = trig_info.trig_timestamp[31:0];
    words[REG_TS_MSB]  = {20'd0, trig_info.trig_timestamp[43:32]};
    // Threshold then count, per soft error
    words[REG_THRES_DC]  = thresholds.data_corrupt;
    words[REG_CNT_DC]    = counts.data_corrupt;
    words[REG_THRES_TTC] = thresholds.unknown_ttc;
    words[REG_CNT_TTC]   = counts.unknown_ttc;
    words[REG_THRES_DDR] = thresholds.ddr3_overflow;
    words[REG_CNT_DDR]   = counts.ddr3_overflow;
  end

  // Read mux, unmapped addresses give zero
  always_comb begin
    rd_word = '0;
    if (rd_addr < NUM_STATUS_REGS) begin
      rd_word = words[rd_addr];
    end
  end

  // Read data loads only on a request
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= rd_word;
    end
  end

  // Valid one cycle after the request
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  a_rd_addr_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    rd_en |-> !$isunknown(rd_addr)
  ) else $error("read address unknown during rd_en");

endmodule

//--- rider_status_top.sv
`timescale 1ns/1ps

module rider_status_top #(
  parameter int unsigned WINDOW_CYCLES = 64,
  parameter int unsigned MAX_TRIGS     = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  // Strobes
  input  logic                    cs_mismatch,
  input  logic                    unknown_cmd,
  input  logic                    ddr3_overflow,
  input  logic                    trig,
  input  logic                    err_clear,
  // Levels
  input  logic                    pll_unlock,
  input  logic                    ddr3_overflow_warning,
  input  logic                    daq_almost_full,
  input  logic                    prog_chan_done,
  input  logic                    async_mode,
  // Trigger check pulses, TTC and channel side
  input  logic                    trig_num_err_tt,
  input  logic                    trig_type_err_tt,
  input  logic                    trig_num_err_cm,
  input  logic                    trig_type_err_cm,
  input  rider_pkg::soft_cnt_t    thresholds,
  // Host read port
  input  logic                    rd_en,
  input  rider_pkg::status_addr_t rd_addr,
  output logic [31:0]             rd_data,
  output logic                    rd_valid,
  output rider_pkg::tts_state_e   tts_state
);

  import rider_pkg::*;

  soft_cnt_t  counts;
  logic       err_data_corrupt;
  logic       err_unknown_ttc;
  trig_info_t trig_info;
  logic       trig_rate_err;
  hard_err_t  hard_err;
  hard_err_t  err_latched;

  // Hard error collection
  always_comb begin
    hard_err              = '0;
    hard_err.data_corrupt = err_data_corrupt;
    hard_err.unknown_ttc  = err_unknown_ttc;
    hard_err.trig_rate    = trig_rate_err;
    hard_err.pll_unlock   = pll_unlock;
    hard_err.trig_num_tt  = trig_num_err_tt;
    hard_err.trig_type_tt = trig_type_err_tt;
    hard_err.trig_num_cm  = trig_num_err_cm;
    hard_err.trig_type_cm = trig_type_err_cm;
  end

  soft_err_counter soft_err_counter_i (
    .clk, .arst_n, .cs_mismatch, .unknown_cmd, .ddr3_overflow, .err_clear,
    .thresholds, .counts, .err_data_corrupt, .err_unknown_ttc
  );

  trig_monitor #(
    .WINDOW_CYCLES(WINDOW_CYCLES),
    .MAX_TRIGS    (MAX_TRIGS)
  ) trig_monitor_i (
    .clk, .arst_n, .trig, .err_clear, .trig_info, .trig_rate_err
  );

  tts_fsm tts_fsm_i (
    .clk, .arst_n, .hard_err, .ddr3_overflow_warning, .daq_almost_full,
    .err_clear, .tts_state, .err_latched
  );

  status_reg_block status_reg_block_i (
    .clk, .arst_n, .rd_en, .rd_addr, .prog_chan_done, .async_mode,
    .ddr3_overflow_warning, .daq_almost_full, .err_latched, .tts_state,
    .trig_info, .thresholds, .counts, .rd_data, .rd_valid
  );

endmodule

//--- rider_status_tb.sv
`timescale 1ns/1ps

module rider_status_tb;

  import rider_pkg::*;

  localparam int unsigned CLK_PERIOD    = 40;
  localparam int unsigned WINDOW_CYCLES = 64;
  localparam int unsigned MAX_TRIGS     = 4;
  localparam int unsigned THRES         = 20;  // Same threshold for all soft errors
  localparam int unsigned TEST_CYCLES   = 8 * WINDOW_CYCLES + 200;  // Rate test dominates

  logic         clk = 1'b0;
  logic         arst_n;
  logic         cs_mismatch, unknown_cmd, ddr3_overflow, trig, err_clear;
  logic         pll_unlock, ddr3_overflow_warning, daq_almost_full;
  logic         prog_chan_done, async_mode;
  logic         trig_num_err_tt, trig_type_err_tt, trig_num_err_cm, trig_type_err_cm;
  soft_cnt_t    thresholds;
  logic         rd_en;
  status_addr_t rd_addr;
  logic [31:0]  rd_data;
  logic         rd_valid;
  tts_state_e   tts_state;

  logic [31:0]  rand_state = 32'h3010_bbe1;
  int unsigned  cycle_cnt;      // Edges since reset release
  int unsigned  trig_total = 0; // Triggers sent so far
  int unsigned  err_count = 0;

  rider_status_top #(
    .WINDOW_CYCLES(WINDOW_CYCLES),
    .MAX_TRIGS    (MAX_TRIGS)
  ) dut_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Same phase as the DUT timestamp
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      stop_on_error($sformatf("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                              $time, name, actual, expected));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;  // Inputs change just after the edge
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) next_cycle();
  endtask

  // Read data comes back exactly one cycle after the request
  task automatic read_reg(input status_addr_t addr, output logic [31:0] data);
    rd_en   = 1'b1;
    rd_addr = addr;
    next_cycle();
    rd_en   = 1'b0;
    if (rd_valid !== 1'b1) begin
      stop_on_error($sformatf("No rd_valid one cycle after reading address %0d", addr));
    end
    data = rd_data;
  endtask

  task automatic check_reg(input status_addr_t addr, input logic [31:0] expected);
    logic [31:0] data;
    read_reg(addr, data);
    check_value($sformatf("reg %0d", addr), data, expected);
  endtask

  task automatic check_tts(input tts_state_e expected);
    check_value("tts_state", 32'(tts_state), 32'(expected));
  endtask

  task automatic pulse_trig();
    trig = 1'b1;
    next_cycle();
    trig = 1'b0;
    trig_total++;
  endtask

  task automatic clear_errors();
    err_clear = 1'b1;
    next_cycle();
    err_clear = 1'b0;
    next_cycle();
    check_tts(TTS_READY);
    check_reg(REG_ERROR, 32'h0);
  endtask

  task automatic test_reset_values();
    check_value("rd_valid", rd_valid, 32'h0);  // No read yet
    // Status bits 30 and 29 above the revision bytes
    check_reg(REG_VERSION, (32'(prog_chan_done) << 30) | (32'(async_mode) << 29) |
                           {8'd0, MAJOR_REV, MINOR_REV, PATCH_REV});
    check_tts(TTS_READY);
    check_reg(REG_ERROR, 32'h0);
    check_reg(REG_TRIG_NUM, 32'h0);
    check_reg(REG_CNT_DC, 32'h0);
    check_reg(REG_CNT_TTC, 32'h0);
    check_reg(REG_CNT_DDR, 32'h0);
  endtask

  task automatic test_soft_counters();
    int unsigned n_dc, n_ttc, n_ddr;
    n_dc  = next_rand() % 16;  // All below threshold
    n_ttc = next_rand() % 16;
    n_ddr = next_rand() % 16;
    for (int unsigned i = 0; i < 16; i++) begin
      cs_mismatch   = i < n_dc;
      unknown_cmd   = i < n_ttc;
      ddr3_overflow = i < n_ddr;
      next_cycle();
    end
    cs_mismatch   = 1'b0;
    unknown_cmd   = 1'b0;
    ddr3_overflow = 1'b0;
    check_reg(REG_CNT_DC, n_dc);
    check_reg(REG_CNT_TTC, n_ttc);
    check_reg(REG_CNT_DDR, n_ddr);
    check_reg(REG_THRES_DC, THRES);
    check_tts(TTS_READY);
    // Count equal to the threshold is no error yet
    cs_mismatch = 1'b1;
    wait_cycles(THRES - n_dc);
    cs_mismatch = 1'b0;
    next_cycle();
    check_tts(TTS_READY);
    // One past the threshold
    cs_mismatch = 1'b1;
    next_cycle();
    cs_mismatch = 1'b0;
    next_cycle();
    check_tts(TTS_ERROR);
    check_reg(REG_ERROR, 32'h1);
    clear_errors();
    check_reg(REG_CNT_DC, 32'h0);
    check_reg(REG_CNT_TTC, 32'h0);
    check_reg(REG_CNT_DDR, 32'h0);
  endtask

  task automatic test_trigger_spacing();
    int unsigned gap, t0;
    logic [31:0] ts_first, ts_second;
    gap = 8 + next_rand() % 8;  // Long enough for a read in between
    t0  = cycle_cnt;
    pulse_trig();
    read_reg(REG_TS_LSB, ts_first);
    while (cycle_cnt != t0 + gap) next_cycle();
    pulse_trig();
    read_reg(REG_TS_LSB, ts_second);
    check_value("timestamp gap", ts_second - ts_first, gap);
    check_reg(REG_TRIG_NUM, trig_total);
  endtask

  task automatic test_trigger_rate();
    int unsigned waited;
    wait_cycles(2 * WINDOW_CYCLES);  // Earlier triggers age out
    repeat (8) begin
      pulse_trig();
      wait_cycles(WINDOW_CYCLES / MAX_TRIGS - 1);  // At most MAX_TRIGS per window
    end
    wait_cycles(WINDOW_CYCLES);
    check_reg(REG_ERROR, 32'h0);
    check_tts(TTS_READY);
    // Burst well inside one window
    while (cycle_cnt % WINDOW_CYCLES != 8) next_cycle();
    trig = 1'b1;
    wait_cycles(MAX_TRIGS + 1);
    trig = 1'b0;
    trig_total += MAX_TRIGS + 1;
    waited = 0;
    while (tts_state != TTS_ERROR) begin
      if (waited == 2 * WINDOW_CYCLES) begin
        stop_on_error("Trigger rate error not raised within two windows");
      end
      next_cycle();
      waited++;
    end
    check_reg(REG_ERROR, 32'h4);
    check_reg(REG_TRIG_NUM, trig_total);
    clear_errors();
  endtask

  task automatic test_tts_priority();
    ddr3_overflow_warning = 1'b1;
    next_cycle();
    check_tts(TTS_WARN);
    check_reg(REG_ERROR, 32'h100);  // Warning bit above latched errors
    daq_almost_full = 1'b1;
    next_cycle();
    check_tts(TTS_BUSY);
    check_reg(REG_TTS, {27'd0, 1'b1, 4'(TTS_BUSY)});
    ddr3_overflow_warning = 1'b0;
    next_cycle();
    check_tts(TTS_BUSY);
    daq_almost_full = 1'b0;
    next_cycle();
    check_tts(TTS_READY);
    pll_unlock = 1'b1;
    next_cycle();
    pll_unlock = 1'b0;
    next_cycle();
    check_tts(TTS_ERROR);
    wait_cycles(5);
    check_tts(TTS_ERROR);  // Still there after the cause dropped
    trig_num_err_cm = 1'b1;
    next_cycle();
    trig_num_err_cm = 1'b0;
    check_reg(REG_ERROR, 32'h48);  // pll_unlock bit 3, trig_num_cm bit 6
    clear_errors();
  endtask

  task automatic test_unmapped_reads();
    for (int unsigned a = NUM_STATUS_REGS; a < 16; a++) begin
      check_reg(status_addr_t'(a), 32'h0);
    end
    next_cycle();
    check_value("rd_valid", rd_valid, 32'h0);  // Pulse ends with the requests
  endtask

  // Watchdog
  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    stop_on_error("Timeout, the tests did not finish in time");
  end

  initial begin
    arst_n = 1'b0;
    {cs_mismatch, unknown_cmd, ddr3_overflow, trig, err_clear} = '0;
    {pll_unlock, ddr3_overflow_warning, daq_almost_full} = '0;
    prog_chan_done = 1'b1;
    async_mode     = 1'b0;
    {trig_num_err_tt, trig_type_err_tt, trig_num_err_cm, trig_type_err_cm} = '0;
    thresholds = '{data_corrupt: THRES, unknown_ttc: THRES, ddr3_overflow: THRES};
    rd_en   = 1'b0;
    rd_addr = '0;
    repeat (3) @(posedge clk);
    #2 arst_n = 1'b1;
    next_cycle();
    test_reset_values();
    test_soft_counters();
    test_trigger_spacing();
    test_trigger_rate();
    test_tts_priority();
    test_unmapped_reads();
    if (err_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_on_error("Checks failed during the run");
    end
  end

endmodule

//--- sim.f
rider_pkg.sv
soft_err_counter.sv
trig_monitor.sv
tts_fsm.sv
status_reg_block.sv
rider_status_top.sv
rider_status_tb.sv

//--- Bender.yml
package:
  name: rider_status

sources:
  - rider_pkg.sv
  - soft_err_counter.sv
  - trig_monitor.sv
  - tts_fsm.sv
  - status_reg_block.sv
  - rider_status_top.sv
  - target: simulation
    files:
      - rider_status_tb.sv
